//--- compile.f
mini_rv_pkg.sv
uart_programmer.sv
instr_mem.sv
regfile.sv
exec_core.sv
riscv_core_top.sv
tb_riscv_core_top.sv

//--- tb_riscv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_core_top;

    localparam int clks_per_bit = 8;
    localparam int n_rows = 17;
    // idle cycles after the last instruction of a run
    localparam int run_tail = 4;
    // serial bytes dominate, the margin covers reset, read back and debug reads
    localparam int timeout_cycles =
        n_rows * 4 * 10 * clks_per_bit + n_rows + 2 * run_tail + 200;

    // one program row, the checked register and its expected value
    typedef struct packed {
        logic [31:0] word;
        logic        chk;
        logic [4:0]  chk_reg;
        logic [31:0] exp_val;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        debug;
    logic        rx;
    logic        prog;
    logic [4:0]  debug_input;
    logic [31:0] debug_output;

    row_t        tab [n_rows];
    // program a in rows 0..11, program b in rows 12..16
    int          prog_base [2] = '{0, 12};
    int          prog_len [2] = '{12, 5};
    logic [31:0] disp_exp [2];
    logic [31:0] model_regs [32];
    logic [31:0] model_disp;
    logic [31:0] lfsr_state;
    int          wr_seen;
    int          cycle_cnt;
    int          n_checks;
    int          n_errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;

    riscv_core_top #(
        .clks_per_bit (clks_per_bit)
    ) uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .debug        (debug),
        .rx           (rx),
        .prog         (prog),
        .debug_input  (debug_input),
        .debug_output (debug_output)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // hard stop if something never finishes
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout after %0d cycles, the run did not finish", cycle_cnt);
            $display("Result: FAILED");
            $finish;
        end
    end

    // count instruction store write strobes
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wr_seen <= 0;
        else if (uut.imem_wr.wr_en)
            wr_seen <= wr_seen + 1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // random bits and instruction encoders
    ////////////////////////////////////////////////////////////////////////////

    // x^32 + x^22 + x^2 + x + 1, one bit per call
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [11:0] rand_imm12();
        logic [11:0] v;
        v = '0;
        for (int i = 0; i < 12; i++)
            v = {v[10:0], lfsr_step()};
        return v;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [4:0] rd);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    // sw rs2, imm(rs1)
    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // isa model and stimulus table
    ////////////////////////////////////////////////////////////////////////////

    // runs one program from pc 0 until a jal to itself, registers persist
    task automatic model_run(input int base, input int len);
        int          pc;
        int          steps;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] off;
        logic        wr;
        logic        stop;
        pc = 0;
        steps = 0;
        stop = 1'b0;
        while (!stop && steps < 4 * len) begin
            w = tab[base + pc / 4].word;
            a = model_regs[w[19:15]];
            b = model_regs[w[24:20]];
            wr = 1'b0;
            res = '0;
            off = 32'd4;
            case (w[6:0])
                7'b0010011: begin
                    wr = (w[14:12] == 3'd0);
                    res = a + {{20{w[31]}}, w[31:20]};
                end
                7'b0110011: begin
                    wr = 1'b1;
                    case (w[14:12])
                        3'd0:    res = w[30] ? a - b : a + b;
                        3'd4:    res = a ^ b;
                        3'd6:    res = a | b;
                        3'd7:    res = a & b;
                        default: wr = 1'b0;
                    endcase
                end
                7'b0110111: begin
                    wr = 1'b1;
                    res = {w[31:12], 12'h000};
                end
                7'b0100011: begin
                    // store goes to the display, address unused
                    if (w[14:12] == 3'b010)
                        model_disp = b;
                end
                7'b1101111: begin
                    wr = 1'b1;
                    res = 32'(pc + 4);
                    off = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                    stop = (off == 32'd0);
                end
                default: ;
            endcase
            if (wr && w[11:7] != 5'd0)
                model_regs[w[11:7]] = res;
            // 32 words of 4 bytes
            pc = (pc + int'(off)) & 127;
            if (pc / 4 >= len)
                stop = 1'b1;
            steps++;
        end
    endtask

    task automatic set_row(input int idx, input logic [31:0] w, input logic chk,
                           input logic [4:0] r);
        tab[idx].word = w;
        tab[idx].chk = chk;
        tab[idx].chk_reg = r;
        tab[idx].exp_val = '0;
    endtask

    task automatic build_tables();
        lfsr_state = 32'ha75e;
        // program a, alu mix, x0 write, two stores, jal self loop
        set_row(0, i_type(rand_imm12(), 5'd0, 5'd1), 1'b1, 5'd1);
        set_row(1, i_type(rand_imm12(), 5'd0, 5'd2), 1'b1, 5'd2);
        set_row(2, r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), 1'b1, 5'd3);
        set_row(3, r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd4), 1'b1, 5'd4);
        set_row(4, r_type(7'h00, 5'd2, 5'd1, 3'd7, 5'd5), 1'b1, 5'd5);
        set_row(5, r_type(7'h00, 5'd2, 5'd1, 3'd6, 5'd6), 1'b1, 5'd6);
        set_row(6, r_type(7'h00, 5'd2, 5'd1, 3'd4, 5'd7), 1'b1, 5'd7);
        set_row(7, u_type(20'habcde, 5'd8), 1'b1, 5'd8);
        set_row(8, i_type(rand_imm12(), 5'd1, 5'd0), 1'b1, 5'd0);
        set_row(9, s_type(12'd0, 5'd3, 5'd0), 1'b0, 5'd0);
        set_row(10, s_type(12'd4, 5'd7, 5'd0), 1'b0, 5'd0);
        set_row(11, j_type(21'd0, 5'd9), 1'b1, 5'd9);
        // program b, reads x1 left over from program a
        set_row(12, i_type(rand_imm12(), 5'd1, 5'd10), 1'b1, 5'd10);
        set_row(13, u_type(20'h13579, 5'd11), 1'b1, 5'd11);
        set_row(14, r_type(7'h00, 5'd11, 5'd10, 3'd4, 5'd12), 1'b1, 5'd12);
        set_row(15, s_type(12'hffc, 5'd12, 5'd0), 1'b0, 5'd0);
        set_row(16, j_type(21'd0, 5'd13), 1'b1, 5'd13);
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        model_disp = '0;
        for (int p = 0; p < 2; p++) begin
            model_run(prog_base[p], prog_len[p]);
            for (int i = prog_base[p]; i < prog_base[p] + prog_len[p]; i++)
                if (tab[i].chk)
                    tab[i].exp_val = model_regs[tab[i].chk_reg];
            disp_exp[p] = model_disp;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checks and bus level tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        n_checks++;
        assert (got === want) else begin
            $display("MISMATCH %s: got 0x%08h, expected 0x%08h", what, got, want);
            n_errors++;
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, test_errors);
        end
        test_errors = 0;
    endtask

    // 8n1 frame, lsb first, clks_per_bit clocks per bit
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            rx = frame[i];
            repeat (clks_per_bit - 1) @(negedge clk);
        end
    endtask

    task automatic load_program(input int p);
        int          target;
        logic [31:0] w;
        @(negedge clk);
        prog = 1'b1;
        target = wr_seen + prog_len[p];
        for (int i = prog_base[p]; i < prog_base[p] + prog_len[p]; i++) begin
            w = tab[i].word;
            // little endian on the wire
            send_byte(w[7:0]);
            send_byte(w[15:8]);
            send_byte(w[23:16]);
            send_byte(w[31:24]);
        end
        while (wr_seen < target)
            @(negedge clk);
        // one more cycle to catch a stray strobe
        @(negedge clk);
        check_value("write strobe count", wr_seen, target);
    endtask

    // prog still high, debug_output shows the addressed word
    task automatic read_back(input int p);
        for (int i = 0; i < prog_len[p]; i++) begin
            @(negedge clk);
            debug_input = 5'(i);
            @(negedge clk);
            check_value($sformatf("debug_output (imem[%0d])", i), debug_output,
                        tab[prog_base[p] + i].word);
        end
    endtask

    task automatic run_program(input int p);
        @(negedge clk);
        prog = 1'b0;
        debug_input = '0;
        // one instruction per clock up to the self loop
        repeat (prog_len[p] + run_tail) @(negedge clk);
        check_value("debug_output (display)", debug_output, disp_exp[p]);
    endtask

    task automatic read_registers(input int p);
        @(negedge clk);
        debug = 1'b1;
        for (int i = prog_base[p]; i < prog_base[p] + prog_len[p]; i++) begin
            if (tab[i].chk) begin
                debug_input = tab[i].chk_reg;
                @(negedge clk);
                check_value($sformatf("debug_output (x%0d)", tab[i].chk_reg),
                            debug_output, tab[i].exp_val);
            end
        end
        debug = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        rst_n = 1'b0;
        rx = 1'b1;
        prog = 1'b0;
        debug = 1'b0;
        debug_input = '0;
        n_checks = 0;
        n_errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        build_tables();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        @(negedge clk);
        check_value("debug_output after reset", debug_output, 32'd0);
        end_test("reset");

        // second pass reprograms over the first
        for (int p = 0; p < 2; p++) begin
            load_program(p);
            end_test($sformatf("load program %0d", p));
            read_back(p);
            end_test($sformatf("read back program %0d", p));
            run_program(p);
            end_test($sformatf("display program %0d", p));
            read_registers(p);
            end_test($sformatf("registers program %0d", p));
        end

        $display("checks %0d, errors %0d, tests %0d, tests failed %0d",
                 n_checks, n_errors, tests_run, tests_failed);
        if (n_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- riscv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_core_top #(
    parameter int clks_per_bit = 8,
    parameter int imem_words   = mini_rv_pkg::imem_words
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        debug,
    input  logic        rx,
    input  logic        prog,
    input  logic [4:0]  debug_input,
    output logic [31:0] debug_output
);

    mini_rv_pkg::imem_wr_t               imem_wr;
    logic [mini_rv_pkg::imem_addr_w-1:0] imem_addr;
    logic [31:0]                         ins;
    logic [31:0]                         ins_view;
    logic [31:0]                         dbg_rdata;
    logic [31:0]                         display;

    ////////////////////////////////////////////////////////////////////////////
    // blocks
    ////////////////////////////////////////////////////////////////////////////

    // serial loader
    uart_programmer #(
        .clks_per_bit (clks_per_bit)
    ) u_uart_programmer (
        .clk     (clk),
        .rst_n   (rst_n),
        .rx      (rx),
        .prog    (prog),
        .imem_wr (imem_wr)
    );

    instr_mem #(
        .imem_words (imem_words)
    ) u_instr_mem (
        .clk     (clk),
        .imem_wr (imem_wr),
        .rd_addr (imem_addr),
        .ins     (ins)
    );

    exec_core #(
        .imem_words (imem_words)
    ) u_exec_core (
        .clk         (clk),
        .rst_n       (rst_n),
        .prog        (prog),
        .debug       (debug),
        .debug_input (debug_input),
        .imem_addr   (imem_addr),
        .ins         (ins),
        .ins_view    (ins_view),
        .dbg_rdata   (dbg_rdata),
        .display     (display)
    );

    // debug port, prog beats debug beats display
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            debug_output <= '0;
        else if (prog)
            debug_output <= ins_view;
        else if (debug)
            debug_output <= dbg_rdata;
        else
            debug_output <= display;
    end

endmodule

`default_nettype wire

//--- exec_core.sv
`timescale 1ns/1ps
`default_nettype none

module exec_core #(
    parameter int imem_words = mini_rv_pkg::imem_words
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                prog,
    input  logic                                debug,
    input  logic [4:0]                          debug_input,
    output logic [mini_rv_pkg::imem_addr_w-1:0] imem_addr,
    input  logic [31:0]                         ins,
    output logic [31:0]                         ins_view,
    output logic [31:0]                         dbg_rdata,
    output logic [31:0]                         display
);

    // pc wraps at the end of the instruction store
    localparam logic [31:0] pc_mask = 32'(4 * imem_words - 1);

    logic [31:0]           pc;
    logic [31:0]           pc_plus4;
    logic [31:0]           pc_next;
    logic                  run;
    mini_rv_pkg::decoded_t dec;
    mini_rv_pkg::rf_wr_t   rf_wr;
    logic [4:0]            ra1;
    logic [31:0]           rs1_data;
    logic [31:0]           rs2_data;
    logic [31:0]           alu_b;
    logic [31:0]           alu_res;

    // stepping only outside program and debug modes
    assign run = !prog && !debug;

    ////////////////////////////////////////////////////////////////////////////
    // fetch
    ////////////////////////////////////////////////////////////////////////////

    // in program mode the host peeks at the store
    assign imem_addr = prog ? debug_input : pc[mini_rv_pkg::imem_addr_w+1:2];
    assign ins_view  = ins;

    ////////////////////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        dec           = '0;
        dec.rd        = ins[11:7];
        dec.rs1       = ins[19:15];
        dec.rs2       = ins[24:20];
        dec.alu_op    = mini_rv_pkg::alu_add;
        case (ins[6:0])
            mini_rv_pkg::op_r: begin
                dec.reg_write = 1'b1;
                case (ins[14:12])
                    3'b000:  dec.alu_op = ins[30] ? mini_rv_pkg::alu_sub : mini_rv_pkg::alu_add;
                    3'b100:  dec.alu_op = mini_rv_pkg::alu_xor;
                    3'b110:  dec.alu_op = mini_rv_pkg::alu_or;
                    3'b111:  dec.alu_op = mini_rv_pkg::alu_and;
                    // unsupported funct3 acts as a nop
                    default: dec.reg_write = 1'b0;
                endcase
            end
            mini_rv_pkg::op_imm: begin
                // addi only
                dec.imm       = {{20{ins[31]}}, ins[31:20]};
                dec.use_imm   = 1'b1;
                dec.reg_write = (ins[14:12] == 3'b000);
            end
            mini_rv_pkg::op_lui: begin
                dec.imm       = {ins[31:12], 12'b0};
                dec.use_imm   = 1'b1;
                dec.alu_op    = mini_rv_pkg::alu_pass_b;
                dec.reg_write = 1'b1;
            end
            mini_rv_pkg::op_jal: begin
                // j-type offset
                dec.imm       = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                dec.is_jal    = 1'b1;
                dec.reg_write = 1'b1;
            end
            mini_rv_pkg::op_store: begin
                // sw only, the display takes rs2 and no address
                dec.is_store = (ins[14:12] == 3'b010);
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // register file and alu
    ////////////////////////////////////////////////////////////////////////////

    // debug reads borrow port 1
    assign ra1 = debug ? debug_input : dec.rs1;

    regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .ra1   (ra1),
        .ra2   (dec.rs2),
        .rd1   (rs1_data),
        .rd2   (rs2_data),
        .rf_wr (rf_wr)
    );

    assign dbg_rdata = rs1_data;
    assign alu_b     = dec.use_imm ? dec.imm : rs2_data;

    always_comb begin
        case (dec.alu_op)
            mini_rv_pkg::alu_sub:    alu_res = rs1_data - alu_b;
            mini_rv_pkg::alu_and:    alu_res = rs1_data & alu_b;
            mini_rv_pkg::alu_or:     alu_res = rs1_data | alu_b;
            mini_rv_pkg::alu_xor:    alu_res = rs1_data ^ alu_b;
            mini_rv_pkg::alu_pass_b: alu_res = alu_b;
            default:                 alu_res = rs1_data + alu_b;
        endcase
    end

    // writeback takes the link address for jal
    assign pc_plus4    = pc + 32'd4;
    assign rf_wr.wr_en = run && dec.reg_write;
    assign rf_wr.rd    = dec.rd;
    assign rf_wr.data  = dec.is_jal ? pc_plus4 : alu_res;

    ////////////////////////////////////////////////////////////////////////////
    // pc and display
    ////////////////////////////////////////////////////////////////////////////

    assign pc_next = (dec.is_jal ? (pc + dec.imm) : pc_plus4) & pc_mask;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= '0;
            display <= '0;
        end else if (prog) begin
            // restart from 0 after a load
            pc <= '0;
        end else if (run) begin
            pc <= pc_next;
            if (dec.is_store)
                display <= rs2_data;
        end
    end

    // debug freezes the core
    a_pc_hold_debug: assert property (
        @(posedge clk) disable iff (!rst_n) (debug && !prog) |=> $stable(pc)
    );

endmodule

`default_nettype wire

//--- regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [4:0]            ra1,
    input  logic [4:0]            ra2,
    output logic [31:0]           rd1,
    output logic [31:0]           rd2,
    input  mini_rv_pkg::rf_wr_t   rf_wr
);

    // storage for x1..x31 only
    logic [mini_rv_pkg::xlen-1:0] regs [1:31];

    ////////////////////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (rf_wr.wr_en && (rf_wr.rd != 5'd0)) begin
            regs[rf_wr.rd] <= rf_wr.data;
        end
    end

    // async reads with x0 forced to zero
    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

    // a write aimed at x0 changes nothing that port 1 reads
    a_x0_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rf_wr.wr_en && (rf_wr.rd == 5'd0)) |=> ((ra1 != $past(ra1)) || $stable(rd1))
    );

endmodule

`default_nettype wire

//--- instr_mem.sv
`timescale 1ns/1ps
`default_nettype none

module instr_mem #(
    parameter int imem_words = mini_rv_pkg::imem_words
) (
    input  logic                                clk,
    input  mini_rv_pkg::imem_wr_t               imem_wr,
    input  logic [mini_rv_pkg::imem_addr_w-1:0] rd_addr,
    output logic [31:0]                         ins
);

    // word storage, loaded only by the programmer
    logic [31:0] mem [imem_words];

    ////////////////////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////////////////////

    // one word per strobe
    always_ff @(posedge clk) begin
        if (imem_wr.wr_en)
            mem[imem_wr.addr] <= imem_wr.data;
    end

    ////////////////////////////////////////////////////////////////////////////
    // read port
    ////////////////////////////////////////////////////////////////////////////

    // combinational fetch, same cycle as the address
    assign ins = mem[rd_addr];

endmodule

`default_nettype wire

//--- uart_programmer.sv
`timescale 1ns/1ps
`default_nettype none

module uart_programmer #(
    parameter int clks_per_bit = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  rx,
    input  logic                  prog,
    output mini_rv_pkg::imem_wr_t imem_wr
);

    localparam int cnt_w = $clog2(clks_per_bit);
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clks_per_bit - 1);
    // first sample point, middle of the start bit
    localparam logic [cnt_w-1:0] half_cnt = cnt_w'((clks_per_bit - 1) / 2);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } rx_state_e;

    rx_state_e                          state;
    logic [cnt_w-1:0]                   bit_cnt;
    logic [2:0]                         bit_idx;
    logic [7:0]                         rx_byte;
    logic [1:0]                         byte_cnt;
    logic [mini_rv_pkg::imem_addr_w-1:0] addr_cnt;
    logic [mini_rv_pkg::xlen-1:0]       word_sh;
    logic                               rx_meta;
    logic                               rx_sync;
    logic                               byte_done;

    // rx comes from off chip
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // stop bit sampled high, byte is good
    assign byte_done = (state == st_stop) && (bit_cnt == last_cnt) && rx_sync;

    ////////////////////////////////////////////////////////////////////////////
    // 8n1 receive fsm
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_idle;
            bit_cnt <= '0;
            bit_idx <= '0;
            rx_byte <= '0;
        end else begin
            case (state)
                st_idle: begin
                    bit_cnt <= '0;
                    bit_idx <= '0;
                    if (!rx_sync)
                        state <= st_start;
                end
                st_start: begin
                    // recheck start bit at its middle, glitches go back to idle
                    if (bit_cnt == half_cnt) begin
                        bit_cnt <= '0;
                        state   <= rx_sync ? st_idle : st_data;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (bit_cnt == last_cnt) begin
                        bit_cnt <= '0;
                        // lsb first
                        rx_byte <= {rx_sync, rx_byte[7:1]};
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= st_stop;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: begin
                    if (bit_cnt == last_cnt) begin
                        bit_cnt <= '0;
                        state   <= st_idle;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // word packing and write strobe
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_cnt      <= '0;
            addr_cnt      <= '0;
            word_sh       <= '0;
            imem_wr.wr_en <= 1'b0;
            imem_wr.addr  <= '0;
            imem_wr.data  <= '0;
        end else begin
            // strobe lasts one cycle
            imem_wr.wr_en <= 1'b0;
            if (!prog) begin
                // outside program mode bytes are dropped, next load starts at 0
                byte_cnt <= '0;
                addr_cnt <= '0;
            end else if (byte_done) begin
                // little endian, newest byte enters at the top
                word_sh  <= {rx_byte, word_sh[31:8]};
                byte_cnt <= byte_cnt + 1'b1;
                if (byte_cnt == 2'd3) begin
                    imem_wr.wr_en <= 1'b1;
                    imem_wr.addr  <= addr_cnt;
                    imem_wr.data  <= {rx_byte, word_sh[31:8]};
                    addr_cnt      <= addr_cnt + 1'b1;
                end
            end
        end
    end

    // no store writes outside program mode
    a_wr_only_in_prog: assert property (
        @(posedge clk) disable iff (!rst_n) imem_wr.wr_en |-> prog
    );

endmodule

`default_nettype wire

//--- mini_rv_pkg.sv
`default_nettype none

package mini_rv_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////////////////////

    // data path width
    localparam int xlen = 32;
    // instruction store depth, in words
    localparam int imem_words = 32;
    // word address into the instruction store
    localparam int imem_addr_w = 5;

    ////////////////////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////////////////////

    // major opcodes the core knows, everything else is a nop
    typedef enum logic [6:0] {
        op_r     = 7'b0110011,
        op_imm   = 7'b0010011,
        op_lui   = 7'b0110111,
        op_jal   = 7'b1101111,
        op_store = 7'b0100011
    } opcode_e;

    // alu functions
    typedef enum logic [2:0] {
        alu_add    = 3'd0,
        alu_sub    = 3'd1,
        alu_and    = 3'd2,
        alu_or     = 3'd3,
        alu_xor    = 3'd4,
        alu_pass_b = 3'd5
    } alu_op_e;

    ////////////////////////////////////////////////////////////////////////////
    // bundles
    ////////////////////////////////////////////////////////////////////////////

    // one word write into the instruction store
    typedef struct packed {
        logic                   wr_en;
        logic [imem_addr_w-1:0] addr;
        logic [xlen-1:0]        data;
    } imem_wr_t;

    // decoder output
    typedef struct packed {
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [xlen-1:0] imm;
        alu_op_e         alu_op;
        logic            use_imm;
        logic            reg_write;
        logic            is_store;
        logic            is_jal;
    } decoded_t;

    // register file write port
    typedef struct packed {
        logic            wr_en;
        logic [4:0]      rd;
        logic [xlen-1:0] data;
    } rf_wr_t;

endpackage

`default_nettype wire
